// ==== source/trellisPkg.sv ====
/*
 * SOQPSK trellis front end shared definitions
 * sample and branch widths, zero path delay depth, phase error
 * saturation words and monitor DAC select codes
 */

package trellisPkg;

   // ---------------------------------------------------------------------
   // datapath widths
   // ---------------------------------------------------------------------
   // carrier loop and matched filter samples, signed
   localparam int sampleBits = 18;
   // one rotated branch input component
   localparam int rotBits = 10;
   // raw decoder phase error, signed
   localparam int phErrInBits = 10;
   // saturated phase error
   localparam int phErrBits = 8;
   // decoder path index
   localparam int indexBits = 2;

   // zero path delay in symbol enables, matches matched filter latency
   localparam int zeroDelay = 4;
   // 0, 90, 180, 270 degrees
   localparam int numRot = 4;

   // ---------------------------------------------------------------------
   // phase error saturation
   // ---------------------------------------------------------------------
   localparam logic [phErrBits-1:0] phErrPosSat = 8'h7f;
   localparam logic [phErrBits-1:0] phErrNegSat = 8'h81;

   // ---------------------------------------------------------------------
   // monitor DAC selects
   // ---------------------------------------------------------------------
   localparam int dacSelBits = 4;
   localparam logic [dacSelBits-1:0] dacSelI = 4'd0;
   localparam logic [dacSelBits-1:0] dacSelQ = 4'd1;
   localparam logic [dacSelBits-1:0] dacSelPhErr = 4'd2;
   localparam logic [dacSelBits-1:0] dacSelIndex = 4'd3;
   // lsb position of the index in the DAC word
   localparam int dacIndexLsb = 12;

endpackage

// ==== source/zeroPathDelay.sv ====
/*
 * Zero path delay line
 * delays the carrier loop I/Q by zeroDelay symbol enables so the zero
 * path lines up with the matched filter outputs, then halves it
 */

`timescale 1ns/100ps

module zeroPathDelay (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic                              symEn,
   input  logic [trellisPkg::sampleBits-1:0] carrierI,
   input  logic [trellisPkg::sampleBits-1:0] carrierQ,
   output logic [trellisPkg::sampleBits-1:0] zeroI,
   output logic [trellisPkg::sampleBits-1:0] zeroQ
);
   import trellisPkg::*;

   // stage 0 takes the newest sample
   logic [sampleBits-1:0] delayI [zeroDelay];
   logic [sampleBits-1:0] delayQ [zeroDelay];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < zeroDelay; i++) begin
            delayI[i] <= '0;
            delayQ[i] <= '0;
         end
      end else if (symEn) begin
         delayI[0] <= carrierI;
         delayQ[0] <= carrierQ;
         // shift toward the last stage
         for (int i = 1; i < zeroDelay; i++) begin
            delayI[i] <= delayI[i-1];
            delayQ[i] <= delayQ[i-1];
         end
      end
   end

   // halve with sign extension
   // stands in for doubling the minus and plus filter paths
   assign zeroI = {delayI[zeroDelay-1][sampleBits-1], delayI[zeroDelay-1][sampleBits-1:1]};
   assign zeroQ = {delayQ[zeroDelay-1][sampleBits-1], delayQ[zeroDelay-1][sampleBits-1:1]};

endmodule

// ==== source/rotationBank.sv ====
/*
 * Branch input rotation bank
 * truncates one complex sample to rotBits per component and forms the
 * 0, 90, 180 and 270 degree rotations, registered on the symbol enable
 */

`timescale 1ns/100ps

module rotationBank (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic                              symEn,
   input  logic [trellisPkg::sampleBits-1:0] inI,
   input  logic [trellisPkg::sampleBits-1:0] inQ,
   output logic [trellisPkg::rotBits-1:0]    rotReal [trellisPkg::numRot],
   output logic [trellisPkg::rotBits-1:0]    rotImag [trellisPkg::numRot]
);
   import trellisPkg::*;

   // ---------------------------------------------------------------------
   // truncation
   // ---------------------------------------------------------------------
   logic [rotBits-1:0] truncI;
   logic [rotBits-1:0] truncQ;
   logic [rotBits-1:0] negI;
   logic [rotBits-1:0] negQ;

   // keep the top bits only
   assign truncI = inI[sampleBits-1 -: rotBits];
   assign truncQ = inQ[sampleBits-1 -: rotBits];

   // two's complement, most negative value wraps onto itself
   assign negI = -truncI;
   assign negQ = -truncQ;

   // ---------------------------------------------------------------------
   // rotations
   // ---------------------------------------------------------------------
   logic [rotBits-1:0] nextReal [numRot];
   logic [rotBits-1:0] nextImag [numRot];

   always_comb begin
      // 0 deg
      nextReal[0] = truncI;
      nextImag[0] = truncQ;
      // 90 deg
      nextReal[1] = truncQ;
      nextImag[1] = negI;
      // 180 deg
      nextReal[2] = negI;
      nextImag[2] = negQ;
      // 270 deg
      nextReal[3] = negQ;
      nextImag[3] = truncI;
   end

   // branch inputs to the decoder, held between enables
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int r = 0; r < numRot; r++) begin
            rotReal[r] <= '0;
            rotImag[r] <= '0;
         end
      end else if (symEn) begin
         for (int r = 0; r < numRot; r++) begin
            rotReal[r] <= nextReal[r];
            rotImag[r] <= nextImag[r];
         end
      end
   end

endmodule

// ==== source/phaseErrorScaler.sv ====
/*
 * Phase error scaler
 * doubles the raw decoder phase error and saturates it to phErrBits
 * over two symbol enables
 */

`timescale 1ns/100ps

module phaseErrorScaler (
   input  logic                               clk,
   input  logic                               rstN,
   input  logic                               symEn,
   input  logic [trellisPkg::phErrInBits-1:0] phaseError,
   output logic [trellisPkg::phErrBits-1:0]   phErr
);
   import trellisPkg::*;

   // bits above the kept range, plus the sign
   localparam int topBits = phErrInBits - phErrBits + 2;

   logic                 sign;
   logic [topBits-1:0]   topField;
   logic [phErrBits-1:0] dataBits;
   logic                 satPos;
   logic                 satNeg;

   assign sign     = phaseError[phErrInBits-1];
   assign topField = phaseError[phErrInBits-1 -: topBits];

   // ---------------------------------------------------------------------
   // stage 1: double and flag overflow
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rstN) begin
         dataBits <= '0;
         satPos   <= 1'b0;
         satNeg   <= 1'b0;
      end else if (symEn) begin
         dataBits <= {phaseError[phErrBits-2:0], 1'b0};
         // positive and top bits not all zero
         satPos   <= !sign && (topField != '0);
         // negative and top bits not all one
         satNeg   <= sign && (topField != '1);
      end
   end

   // ---------------------------------------------------------------------
   // stage 2: clamp, positive wins
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rstN) begin
         phErr <= '0;
      end else if (symEn) begin
         if (satPos) begin
            phErr <= phErrPosSat;
         end else if (satNeg) begin
            phErr <= phErrNegSat;
         end else begin
            phErr <= dataBits;
         end
      end
   end

endmodule

// ==== source/dacChannel.sv ====
/*
 * Monitor DAC channel
 * selects carrier I, carrier Q, phase error or path index by dacSelect
 * and registers it with a symbol sync strobe
 */

`timescale 1ns/100ps

module dacChannel (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic                              symEn,
   input  logic [trellisPkg::dacSelBits-1:0] dacSelect,
   input  logic [trellisPkg::sampleBits-1:0] carrierI,
   input  logic [trellisPkg::sampleBits-1:0] carrierQ,
   input  logic [trellisPkg::phErrBits-1:0]  phErr,
   input  logic [trellisPkg::indexBits-1:0]  trellisIndex,
   output logic [trellisPkg::sampleBits-1:0] dacData,
   output logic                              dacSync
);
   import trellisPkg::*;

   logic [sampleBits-1:0] phErrWord;
   logic [sampleBits-1:0] indexWord;
   logic [sampleBits-1:0] selWord;

   // phase error left justified
   assign phErrWord = {phErr, {(sampleBits-phErrBits){1'b0}}};
   // index at bits 13:12, zero above and below
   assign indexWord = {{(sampleBits-indexBits-dacIndexLsb){1'b0}}, trellisIndex,
                       {dacIndexLsb{1'b0}}};

   always_comb begin
      case (dacSelect)
         dacSelI:     selWord = carrierI;
         dacSelQ:     selWord = carrierQ;
         dacSelPhErr: selWord = phErrWord;
         dacSelIndex: selWord = indexWord;
         // unused codes show the phase error
         default:     selWord = phErrWord;
      endcase
   end

   // one clock latency, every clock
   always_ff @(posedge clk) begin
      if (!rstN) begin
         dacData <= '0;
         dacSync <= 1'b0;
      end else begin
         dacData <= selWord;
         dacSync <= symEn;
      end
   end

endmodule

// ==== source/trellisFrontEnd.sv ====
/*
 * SOQPSK trellis decoder front end
 * zero path delay, rotated branch inputs for the three matched filter
 * paths, phase error saturation and three monitor DAC channels
 */

`timescale 1ns/100ps

module trellisFrontEnd (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic                              symEn,
   input  logic [trellisPkg::sampleBits-1:0] carrierI,
   input  logic [trellisPkg::sampleBits-1:0] carrierQ,
   input  logic [trellisPkg::sampleBits-1:0] mfmI,
   input  logic [trellisPkg::sampleBits-1:0] mfmQ,
   input  logic [trellisPkg::sampleBits-1:0] mfpI,
   input  logic [trellisPkg::sampleBits-1:0] mfpQ,
   input  logic [trellisPkg::phErrInBits-1:0] phaseError,
   input  logic [trellisPkg::indexBits-1:0]  trellisIndex,
   input  logic [trellisPkg::dacSelBits-1:0] dac0Select,
   input  logic [trellisPkg::dacSelBits-1:0] dac1Select,
   input  logic [trellisPkg::dacSelBits-1:0] dac2Select,
   output logic [trellisPkg::rotBits-1:0]    mfzReal [trellisPkg::numRot],
   output logic [trellisPkg::rotBits-1:0]    mfzImag [trellisPkg::numRot],
   output logic [trellisPkg::rotBits-1:0]    mfmReal [trellisPkg::numRot],
   output logic [trellisPkg::rotBits-1:0]    mfmImag [trellisPkg::numRot],
   output logic [trellisPkg::rotBits-1:0]    mfpReal [trellisPkg::numRot],
   output logic [trellisPkg::rotBits-1:0]    mfpImag [trellisPkg::numRot],
   output logic [trellisPkg::phErrBits-1:0]  phErr,
   output logic [trellisPkg::sampleBits-1:0] dac0Data,
   output logic [trellisPkg::sampleBits-1:0] dac1Data,
   output logic [trellisPkg::sampleBits-1:0] dac2Data,
   output logic                              dac0Sync,
   output logic                              dac1Sync,
   output logic                              dac2Sync
);
   import trellisPkg::*;

   // delayed and halved carrier, the matched filter zero output
   logic [sampleBits-1:0] zeroI;
   logic [sampleBits-1:0] zeroQ;

   // ---------------------------------------------------------------------
   // branch inputs
   // ---------------------------------------------------------------------
   zeroPathDelay u_zeroPath (
      .clk      (clk),
      .rstN     (rstN),
      .symEn    (symEn),
      .carrierI (carrierI),
      .carrierQ (carrierQ),
      .zeroI    (zeroI),
      .zeroQ    (zeroQ)
   );

   // matched filter zero
   rotationBank u_rotZero (
      .clk     (clk),
      .rstN    (rstN),
      .symEn   (symEn),
      .inI     (zeroI),
      .inQ     (zeroQ),
      .rotReal (mfzReal),
      .rotImag (mfzImag)
   );

   // matched filter minus
   rotationBank u_rotMinus (
      .clk     (clk),
      .rstN    (rstN),
      .symEn   (symEn),
      .inI     (mfmI),
      .inQ     (mfmQ),
      .rotReal (mfmReal),
      .rotImag (mfmImag)
   );

   // matched filter plus
   rotationBank u_rotPlus (
      .clk     (clk),
      .rstN    (rstN),
      .symEn   (symEn),
      .inI     (mfpI),
      .inQ     (mfpQ),
      .rotReal (mfpReal),
      .rotImag (mfpImag)
   );

   // ---------------------------------------------------------------------
   // phase error and monitor outputs
   // ---------------------------------------------------------------------
   phaseErrorScaler u_phErrScale (
      .clk        (clk),
      .rstN       (rstN),
      .symEn      (symEn),
      .phaseError (phaseError),
      .phErr      (phErr)
   );

   dacChannel u_dac0 (
      .clk (clk), .rstN (rstN), .symEn (symEn), .dacSelect (dac0Select),
      .carrierI (carrierI), .carrierQ (carrierQ), .phErr (phErr),
      .trellisIndex (trellisIndex), .dacData (dac0Data), .dacSync (dac0Sync)
   );

   dacChannel u_dac1 (
      .clk (clk), .rstN (rstN), .symEn (symEn), .dacSelect (dac1Select),
      .carrierI (carrierI), .carrierQ (carrierQ), .phErr (phErr),
      .trellisIndex (trellisIndex), .dacData (dac1Data), .dacSync (dac1Sync)
   );

   dacChannel u_dac2 (
      .clk (clk), .rstN (rstN), .symEn (symEn), .dacSelect (dac2Select),
      .carrierI (carrierI), .carrierQ (carrierQ), .phErr (phErr),
      .trellisIndex (trellisIndex), .dacData (dac2Data), .dacSync (dac2Sync)
   );

endmodule

// ==== verif/trellisFrontEnd_chk.sv ====
/*
 * Trellis front end timing checks
 * monitor sync strobes, branch input and phase error update timing,
 * and the range of the saturated phase error
 */

`timescale 1ns/100ps

module trellisFrontEndChk (
   input logic                             clk,
   input logic                             rstN,
   input logic                             symEn,
   input logic [trellisPkg::rotBits-1:0]   mfzReal [trellisPkg::numRot],
   input logic [trellisPkg::rotBits-1:0]   mfzImag [trellisPkg::numRot],
   input logic [trellisPkg::rotBits-1:0]   mfmReal [trellisPkg::numRot],
   input logic [trellisPkg::rotBits-1:0]   mfmImag [trellisPkg::numRot],
   input logic [trellisPkg::rotBits-1:0]   mfpReal [trellisPkg::numRot],
   input logic [trellisPkg::rotBits-1:0]   mfpImag [trellisPkg::numRot],
   input logic [trellisPkg::phErrBits-1:0] phErr,
   input logic                             dac0Sync,
   input logic                             dac1Sync,
   input logic                             dac2Sync
);
   import trellisPkg::*;

   // failed assertions so far
   int failCount = 0;

   // all branch inputs of the three banks in one word
   logic [6*numRot*rotBits-1:0] branchWord;

   always_comb begin
      for (int r = 0; r < numRot; r++) begin
         branchWord[(6*r+0)*rotBits +: rotBits] = mfzReal[r];
         branchWord[(6*r+1)*rotBits +: rotBits] = mfzImag[r];
         branchWord[(6*r+2)*rotBits +: rotBits] = mfmReal[r];
         branchWord[(6*r+3)*rotBits +: rotBits] = mfmImag[r];
         branchWord[(6*r+4)*rotBits +: rotBits] = mfpReal[r];
         branchWord[(6*r+5)*rotBits +: rotBits] = mfpImag[r];
      end
   end

   // ---------------------------------------------------------------------
   // properties
   // ---------------------------------------------------------------------
   // sync strobe trails symEn by one clock
   syncAfterEnable: assert property (@(posedge clk) disable iff (!rstN)
      ($rose(dac0Sync) || $rose(dac1Sync) || $rose(dac2Sync)) |-> $past(symEn))
      else begin
         failCount++;
         $error("dacSync rose without symEn one clock earlier");
      end

   // datapath holds between enables
   holdBetweenEnables: assert property (@(posedge clk) disable iff (!rstN)
      ($changed(branchWord) || $changed(phErr)) |-> $past(symEn))
      else begin
         failCount++;
         $error("branch inputs or phErr changed away from an enable");
      end

   // 0x80 is outside the symmetric saturation range
   phErrRange: assert property (@(posedge clk) disable iff (!rstN) phErr != 8'h80)
      else begin
         failCount++;
         $error("phErr took the value 0x80");
      end

endmodule

// ==== verif/trellisFrontEndTb.sv ====
/*
 * Trellis front end testbench
 * directed tests for reset, matched filter rotations, the zero path,
 * phase error saturation and the monitor DAC channels
 */

`timescale 1ns/100ps

module trellisFrontEndTb;
   import trellisPkg::*;

   // the tests need a few hundred cycles
   localparam int maxCycles = 5000;
   // top ten bits at -512 and +511 over arbitrary low bits
   localparam logic [sampleBits-1:0] topNeg = 18'h2005a;
   localparam logic [sampleBits-1:0] topPos = 18'h1ffa5;

   logic clk = 1'b0;
   logic rstN;
   logic symEn;
   logic [sampleBits-1:0] carrierI, carrierQ, mfmI, mfmQ, mfpI, mfpQ;
   logic [phErrInBits-1:0] phaseError;
   logic [indexBits-1:0] trellisIndex;
   logic [dacSelBits-1:0] dac0Select, dac1Select, dac2Select;
   logic [rotBits-1:0] mfzReal [numRot], mfzImag [numRot];
   logic [rotBits-1:0] mfmReal [numRot], mfmImag [numRot];
   logic [rotBits-1:0] mfpReal [numRot], mfpImag [numRot];
   logic [phErrBits-1:0] phErr;
   logic [sampleBits-1:0] dac0Data, dac1Data, dac2Data;
   logic dac0Sync, dac1Sync, dac2Sync;
   int cycleCount = 0;

   trellisFrontEnd u_trellisFrontEnd (.*);

   bind trellisFrontEnd trellisFrontEndChk u_chk (.*);

   // 40 ns period
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= maxCycles) begin
         $display("timeout after %0d cycles, the tests never finished", maxCycles);
         $display("Checks failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   // stop at the first failed bound assertion
   always @(posedge clk) begin
      if (u_trellisFrontEnd.u_chk.failCount != 0) begin
         $display("a timing assertion in the bound checker failed");
         $display("Checks failed");
         $fatal(1, "stopped by a failed assertion");
      end
   end

   // ---------------------------------------------------------------------
   // helpers
   // ---------------------------------------------------------------------
   task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
      if (got !== expected) begin
         $display("error %s: got 0x%0h, expected 0x%0h", name, got, expected);
         $display("Checks failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // DUT takes the inputs driven on this edge at the next one
   task automatic issueEnable();
      symEn <= 1'b1;
      @(posedge clk);
      symEn <= 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
   endtask

   // r quarter turns of the top rotBits bits
   // each turn maps (x, y) to (y, -x)
   function automatic logic [rotBits-1:0] rotatedComponent(logic [sampleBits-1:0] sI,
         logic [sampleBits-1:0] sQ, int r, bit imagPart);
      logic [rotBits-1:0] re;
      logic [rotBits-1:0] im;
      re = rotBits'(sI >> (sampleBits - rotBits));
      im = rotBits'(sQ >> (sampleBits - rotBits));
      for (int k = 0; k < r; k++) begin
         {re, im} = {im, rotBits'(~re + 1'b1)};
      end
      return imagPart ? im : re;
   endfunction

   // doubled and clamped to the saturation words
   function automatic logic [phErrBits-1:0] clampedPhErr(int v);
      if (2 * v > 127) return phErrPosSat;
      if (2 * v < -128) return phErrNegSat;
      return phErrBits'(2 * v);
   endfunction

   // bank 0 zero path, 1 minus, 2 plus
   task automatic compareBank(int bank, logic [sampleBits-1:0] sI, logic [sampleBits-1:0] sQ);
      string bankName;
      logic [rotBits-1:0] gotRe;
      logic [rotBits-1:0] gotIm;
      bankName = (bank == 0) ? "mfz" : (bank == 1) ? "mfm" : "mfp";
      for (int r = 0; r < numRot; r++) begin
         gotRe = (bank == 0) ? mfzReal[r] : (bank == 1) ? mfmReal[r] : mfpReal[r];
         gotIm = (bank == 0) ? mfzImag[r] : (bank == 1) ? mfmImag[r] : mfpImag[r];
         checkValue($sformatf("%sReal[%0d]", bankName, r), 32'(gotRe),
                    32'(rotatedComponent(sI, sQ, r, 1'b0)));
         checkValue($sformatf("%sImag[%0d]", bankName, r), 32'(gotIm),
                    32'(rotatedComponent(sI, sQ, r, 1'b1)));
      end
   endtask

   // ---------------------------------------------------------------------
   // tests
   // ---------------------------------------------------------------------
   task automatic resetState();
      for (int b = 0; b < 3; b++) begin
         compareBank(b, '0, '0);
      end
      checkValue("phErr", 32'(phErr), 0);
      checkValue("dac0Data", 32'(dac0Data), 0);
      checkValue("dac1Data", 32'(dac1Data), 0);
      checkValue("dac2Data", 32'(dac2Data), 0);
      checkValue("dac0Sync", 32'(dac0Sync), 0);
      checkValue("dac1Sync", 32'(dac1Sync), 0);
      checkValue("dac2Sync", 32'(dac2Sync), 0);
   endtask

   task automatic mfRotations();
      logic [sampleBits-1:0] mI;
      logic [sampleBits-1:0] mQ;
      logic [sampleBits-1:0] pI;
      logic [sampleBits-1:0] pQ;
      for (int i = 0; i < 12; i++) begin
         mI = sampleBits'($urandom());
         mQ = sampleBits'($urandom());
         pI = sampleBits'($urandom());
         pQ = sampleBits'($urandom());
         // extremes first
         // -512 negates onto itself
         if (i < 3) begin
            mI = (i == 1) ? topPos : topNeg;
            mQ = (i == 0) ? topPos : topNeg;
            pI = mQ;
            pQ = mI;
         end
         @(posedge clk);
         mfmI <= mI;
         mfmQ <= mQ;
         mfpI <= pI;
         mfpQ <= pQ;
         issueEnable();
         compareBank(1, mI, mQ);
         compareBank(2, pI, pQ);
      end
   endtask

   task automatic zeroPathAlignment();
      logic [sampleBits-1:0] histI [12];
      logic [sampleBits-1:0] histQ [12];
      for (int j = 0; j < 12; j++) begin
         histI[j] = (j == 0) ? topNeg : sampleBits'($urandom());
         histQ[j] = sampleBits'($urandom());
         @(posedge clk);
         carrierI <= histI[j];
         carrierQ <= histQ[j];
         issueEnable();
         // carrier of four enables back halved with sign
         if (j >= 4) begin
            compareBank(0, sampleBits'($signed(histI[j-4]) >>> 1),
                        sampleBits'($signed(histQ[j-4]) >>> 1));
         end
      end
   endtask

   task automatic phaseErrorClamp();
      int values [$];
      values = '{0, 1, -1, 63, -63, 64, -65, 100, -200, 511, -512};
      for (int i = 0; i < 8; i++) begin
         values.push_back(int'($urandom_range(126)) - 63);
      end
      for (int i = 0; i < 4; i++) begin
         values.push_back(64 + int'($urandom_range(447)));
         values.push_back(-65 - int'($urandom_range(447)));
      end
      // flush value whose own result is never checked
      values.push_back(0);
      for (int i = 0; i < values.size(); i++) begin
         @(posedge clk);
         phaseError <= phErrInBits'(values[i]);
         issueEnable();
         // result of the previous enable
         if (i > 0) begin
            checkValue("phErr", 32'(phErr), 32'(clampedPhErr(values[i-1])));
         end
      end
   endtask

   task automatic dacMonitor();
      logic [dacSelBits-1:0] codes [5];
      logic [dacSelBits-1:0] sel [3];
      logic [sampleBits-1:0] ci;
      logic [sampleBits-1:0] cq;
      logic [indexBits-1:0] idx;
      logic [sampleBits-1:0] expected;
      logic [sampleBits-1:0] got;
      int v;
      codes = '{dacSelI, dacSelQ, dacSelPhErr, dacSelIndex, dacSelBits'(9)};
      // two enables through the scaler settle phErr on a known value
      v = int'($urandom_range(126)) - 63;
      @(posedge clk);
      phaseError <= phErrInBits'(v);
      issueEnable();
      @(posedge clk);
      issueEnable();
      // each channel walks the codes from its own start
      for (int s = 0; s < 5; s++) begin
         for (int ch = 0; ch < 3; ch++) begin
            sel[ch] = codes[(s + ch) % 5];
         end
         ci = sampleBits'($urandom());
         cq = sampleBits'($urandom());
         idx = indexBits'($urandom());
         @(posedge clk);
         dac0Select <= sel[0];
         dac1Select <= sel[1];
         dac2Select <= sel[2];
         carrierI <= ci;
         carrierQ <= cq;
         trellisIndex <= idx;
         // one register stage after the source
         @(posedge clk);
         @(negedge clk);
         for (int ch = 0; ch < 3; ch++) begin
            case (sel[ch])
               dacSelI:     expected = ci;
               dacSelQ:     expected = cq;
               dacSelIndex: expected = sampleBits'(idx) << 12;
               default:
                  expected = sampleBits'(clampedPhErr(v)) << (sampleBits - phErrBits);
            endcase
            got = (ch == 0) ? dac0Data : (ch == 1) ? dac1Data : dac2Data;
            checkValue($sformatf("dac%0dData", ch), 32'(got), 32'(expected));
         end
      end
      // sync high only on the clock after a single symEn pulse
      for (int t = 0; t < 3; t++) begin
         @(posedge clk);
         symEn <= (t == 0);
         @(negedge clk);
         checkValue("dac0Sync", 32'(dac0Sync), 32'(t == 1));
         checkValue("dac1Sync", 32'(dac1Sync), 32'(t == 1));
         checkValue("dac2Sync", 32'(dac2Sync), 32'(t == 1));
      end
   endtask

   // ---------------------------------------------------------------------
   // sequence
   // ---------------------------------------------------------------------
   initial begin
      void'($urandom(32'ha98922a6));
      rstN <= 1'b0;
      symEn <= 1'b0;
      carrierI <= '0;
      carrierQ <= '0;
      mfmI <= '0;
      mfmQ <= '0;
      mfpI <= '0;
      mfpQ <= '0;
      phaseError <= '0;
      trellisIndex <= '0;
      dac0Select <= '0;
      dac1Select <= '0;
      dac2Select <= '0;
      repeat (16) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      resetState();
      mfRotations();
      zeroPathAlignment();
      phaseErrorClamp();
      dacMonitor();
      if (u_trellisFrontEnd.u_chk.failCount == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== project.f ====
source/trellisPkg.sv
source/zeroPathDelay.sv
source/rotationBank.sv
source/phaseErrorScaler.sv
source/dacChannel.sv
source/trellisFrontEnd.sv
verif/trellisFrontEnd_chk.sv
verif/trellisFrontEndTb.sv

// ==== Makefile ====
TOP := trellisFrontEndTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
